//--- verilog.f
hw/predecode_isa_pkg.sv
hw/predecode_pipe_pkg.sv
hw/branch_classify.sv
hw/return_addr_stack.sv
hw/branch_resolve.sv
hw/predecode_stage.sv
hw/predecode_top.sv
sim/predecode_assertions.sv
sim/tb_predecode.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and search the log for the fail message.
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_predecode -f verilog.f -o Vtb_predecode \
        && ./obj_dir/Vtb_predecode > sim.log 2>&1 \
        || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && echo "Simulation FAILED" && exit 1 \
        || echo "Simulation passed"

//--- sim/tb_predecode.sv
// Self-checking testbench that drives LFSR stimulus into the pre-decode top level and checks it against a model.

`timescale 1ns/1ps

module tb_predecode
        import predecode_isa_pkg::*, predecode_pipe_pkg::*;
();

        localparam int NUM_OPS   = 2000;
        localparam int RAS_DEPTH = 8;

        logic           clk;
        logic           reset;
        fetch_bundle_t  fetch;
        pipe_ctrl_t     ctrl;
        decode_bundle_t dec;
        logic           clear_from_decode;
        addr_t          pc_from_decode;
        logic           clear_btb;

        // Reference model state.
        decode_bundle_t m_dec;
        logic           m_clear;
        logic           m_btb;
        logic           m_ppc_known;
        addr_t          m_pcfd;
        addr_t          m_ras [RAS_DEPTH];
        int             m_ptr;

        logic [31:0]    lfsr;
        int             errors;
        int             checks;

        predecode_top #(
                .RAS_DEPTH (RAS_DEPTH)
        ) u_predecode_top (
                .i_clk               (clk),
                .i_reset             (reset),
                .i_fetch             (fetch),
                .i_ctrl              (ctrl),
                .o_decode            (dec),
                .o_clear_from_decode (clear_from_decode),
                .o_pc_from_decode    (pc_from_decode),
                .o_clear_btb         (clear_btb)
        );

        initial clk = 1'b0;
        always #2 clk = ~clk;

        // ------------------------------
        // Random source.
        // ------------------------------

        function automatic logic [31:0] next_lfsr(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        // One LFSR step per bit.
        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int k = 0; k < n; k++)
                begin
                        lfsr = next_lfsr(lfsr);
                        v    = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        // Builds an instruction of the requested class.
        function automatic instr_t make_instr(input branch_class_e kind);
                instr_t      w;
                cond_t       c;
                logic [3:0]  r;
                logic [31:0] b;
                c = take_bits(1) ? COND_AL : cond_t'(take_bits(4));
                b = take_bits(28);
                case (kind)
                CLS_CALL:
                        w = {c, 3'b101, b[24:0]};
                CLS_RETURN:
                        case (b[27:26])
                        2'd0:    w = {c, 24'h12FFF1, REG_LR};
                        2'd1:    w = {c, 28'h1A0F00E};
                        2'd2:    w = {c, 3'b100, b[24:21], 1'b1, b[19:16], 1'b1, b[14:0]};
                        default: w = {c, 3'b010, b[24:21], 1'b1, REG_SP, REG_PC, b[11:0]};
                        endcase
                CLS_JUMP_TABLE:
                begin
                        r = (b[19:16] == REG_SP) ? 4'd0 : b[19:16];
                        if (b[27])
                                w = {c, 3'b010, b[24:21], 1'b1, r, REG_PC, b[11:0]};
                        else
                                w = {c, 3'b001, b[26] ? OP_ADD : OP_MOV, b[20], b[19:16],
                                     REG_PC, b[11:0]};
                end
                default:
                begin
                        // Data processing that never writes PC.
                        r = (b[15:12] == REG_PC) ? 4'd0 : b[15:12];
                        w = {c, 2'b00, b[25:16], r, b[11:0]};
                end
                endcase
                return w;
        endfunction

        // ------------------------------
        // Reference model.
        // ------------------------------

        function automatic addr_t branch_target(input fetch_bundle_t f, input branch_class_e k);
                if (k == CLS_CALL)
                        return f.pc_plus_8 + (32'($signed(f.instr[23:0])) << 2);
                return m_ras[(m_ptr + RAS_DEPTH - 1) % RAS_DEPTH];
        endfunction

        task automatic model_step(input fetch_bundle_t f, input pipe_ctrl_t c,
                                  input branch_class_e k);
                decode_bundle_t n;
                logic           clr;
                logic           btb;
                logic           pred;
                logic           known;
                logic           push;
                logic           pop;
                addr_t          tgt;
                addr_t          pcfd;
                n       = '0;
                n.valid = f.valid;
                n.instr = f.instr;
                n.pc    = f.pc;
                n.taken = f.taken;
                n.ppc   = m_dec.ppc;
                clr     = 1'b0;
                btb     = 1'b0;
                push    = 1'b0;
                pop     = 1'b0;
                pcfd    = '0;
                known   = m_ppc_known;
                pred    = (f.taken inside {WT, ST}) || (f.instr[31:28] == COND_AL);
                tgt     = branch_target(f, k);

                if (!f.valid)
                        n.taken = SNT;
                else if ((k == CLS_CALL || k == CLS_RETURN) && pred)
                begin
                        n.ppc = tgt;
                        pcfd  = tgt;
                        known = 1'b1;
                        clr   = !f.pred_valid || (f.pred_target != tgt);
                        if (f.instr[31:28] == COND_AL)
                                n.taken = ST;
                        push = (k == CLS_CALL) && f.instr[24];
                        pop  = (k == CLS_RETURN);
                end
                else if (k == CLS_CALL || k == CLS_RETURN)
                begin
                        n.ppc = f.pc + 32'd4;
                        known = 1'b1;
                end
                else if (k == CLS_OTHER)
                begin
                        n.taken = SNT;
                        if (f.pred_valid)
                        begin
                                clr   = 1'b1;
                                btb   = 1'b1;
                                pcfd  = f.pc + 32'd4;
                                n.ppc = f.pc + 32'd4;
                                known = 1'b1;
                        end
                end

                // Clear and stall priority ahead of the advance.
                if (c.clear_wb || (!c.stall_data && (c.clear_alu || (!c.stall_issue && m_clear))))
                begin
                        m_dec.valid = 1'b0;
                        m_dec.taken = SNT;
                        m_clear     = 1'b0;
                        m_btb       = 1'b0;
                end
                else if (!c.stall_data && !c.stall_issue)
                begin
                        m_dec       = n;
                        m_clear     = clr;
                        m_btb       = btb;
                        m_pcfd      = pcfd;
                        m_ppc_known = known;
                        if (push)
                        begin
                                m_ras[m_ptr] = f.pc + 32'd4;
                                m_ptr        = (m_ptr + 1) % RAS_DEPTH;
                        end
                        else if (pop)
                                m_ptr = (m_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
                end
        endtask

        // ------------------------------
        // Checking.
        // ------------------------------

        task automatic compare_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at %0d ns: %s got %h expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_outputs();
                compare_value("o_decode.valid", 32'(dec.valid), 32'(m_dec.valid));
                compare_value("o_decode.taken", 32'(dec.taken), 32'(m_dec.taken));
                compare_value("o_clear_from_decode", 32'(clear_from_decode), 32'(m_clear));
                compare_value("o_clear_btb", 32'(clear_btb), 32'(m_btb));
                if (m_dec.valid)
                begin
                        compare_value("o_decode.instr", dec.instr, m_dec.instr);
                        compare_value("o_decode.pc", dec.pc, m_dec.pc);
                end
                if (m_ppc_known)
                        compare_value("o_decode.ppc", dec.ppc, m_dec.ppc);
                if (m_clear)
                        compare_value("o_pc_from_decode", pc_from_decode, m_pcfd);
        endtask

        initial
        begin
                fetch_bundle_t f;
                pipe_ctrl_t    c;
                branch_class_e k;
                errors      = 0;
                checks      = 0;
                lfsr        = 32'hc3a18201;
                reset       = 1'b1;
                fetch       = '0;
                ctrl        = '0;
                m_dec       = '0;
                m_clear     = 1'b0;
                m_btb       = 1'b0;
                m_pcfd      = '0;
                m_ppc_known = 1'b0;
                m_ptr       = 0;
                for (int i = 0; i < RAS_DEPTH; i++)
                        m_ras[i] = '0;

                repeat (2) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                check_outputs();

                for (int i = 0; i < NUM_OPS; i++)
                begin
                        k             = branch_class_e'(take_bits(2));
                        f.valid       = take_bits(3) != 0;
                        f.instr       = make_instr(k);
                        f.pc          = take_bits(30) << 2;
                        f.pc_plus_8   = f.pc + 32'd8;
                        f.taken       = taken_e'(take_bits(2));
                        f.pred_valid  = take_bits(1) != 0;
                        f.pred_target = take_bits(1) ? branch_target(f, k) : take_bits(32);
                        // Rare single stall or clear.
                        c = '0;
                        if (take_bits(4) == 0)
                                c = pipe_ctrl_t'(4'b1000 >> take_bits(2));
                        fetch = f;
                        ctrl  = c;
                        model_step(f, c, k);
                        @(negedge clk);
                        check_outputs();
                end

                $display("Errors: %0d of %0d checks", errors, checks);
                if (errors == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        end

        // Watchdog.
        initial
        begin
                #(NUM_OPS * 4 * 4);
                $display("Timeout: the run did not finish within %0d ns", NUM_OPS * 16);
                $display("Checks failed");
                $finish;
        end

endmodule

//--- sim/predecode_assertions.sv
// Concurrent checks on the pre-decode top level, attached to it by bind.

`timescale 1ns/1ps

module predecode_assertions
        import predecode_pipe_pkg::*;
(
        input logic           i_clk,
        input logic           i_reset,
        input pipe_ctrl_t     i_ctrl,
        input decode_bundle_t i_decode,
        input logic           i_clear_from_decode,
        input logic           i_clear_btb
);

        // A BTB clear always redirects fetch.
        a_btb_with_clear: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear_btb |-> i_clear_from_decode)
                else $error("o_clear_btb raised without o_clear_from_decode");

        // Instruction behind a redirect is dropped.
        a_clear_drops_next: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_clear_from_decode && !i_ctrl.stall_data && !i_ctrl.stall_issue)
                |=> !i_decode.valid)
                else $error("valid instruction after a decode clear");

        a_stall_data_holds: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_ctrl.stall_data && !i_ctrl.clear_wb) |=> $stable(i_decode))
                else $error("o_decode changed under stall_data");

endmodule

bind predecode_top predecode_assertions u_predecode_assertions (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_ctrl              (i_ctrl),
        .i_decode            (o_decode),
        .i_clear_from_decode (o_clear_from_decode),
        .i_clear_btb         (o_clear_btb)
);

//--- hw/predecode_top.sv
// Top of the branch pre-decode stage, wiring the classifier, stack, resolver and output register.

`timescale 1ns/1ps

module predecode_top
        import predecode_isa_pkg::*, predecode_pipe_pkg::*;
#(
        parameter int RAS_DEPTH = 8
)
(
        input  logic           i_clk,
        input  logic           i_reset,
        input  fetch_bundle_t  i_fetch,
        input  pipe_ctrl_t     i_ctrl,
        output decode_bundle_t o_decode,
        output logic           o_clear_from_decode,
        output addr_t          o_pc_from_decode,
        output logic           o_clear_btb
);

        branch_class_e  cls;
        addr_t          offset;
        addr_t          ras_top;
        addr_t          push_addr;
        addr_t          pc_from_decode_nxt;
        decode_bundle_t next;
        logic           push;
        logic           pop;
        logic           clear_from_decode_nxt;
        logic           clear_btb_nxt;
        logic           advance;

        branch_classify u_branch_classify (
                .i_instr  (i_fetch.instr),
                .o_class  (cls),
                .o_offset (offset)
        );

        // Stack commits only when the stage register loads.
        return_addr_stack #(
                .RAS_DEPTH (RAS_DEPTH)
        ) u_return_addr_stack (
                .i_clk       (i_clk),
                .i_reset     (i_reset),
                .i_commit    (advance),
                .i_push      (push),
                .i_pop       (pop),
                .i_push_addr (push_addr),
                .o_top       (ras_top)
        );

        // Registered ppc feeds back as the default prediction.
        branch_resolve u_branch_resolve (
                .i_fetch             (i_fetch),
                .i_class             (cls),
                .i_offset            (offset),
                .i_ras_top           (ras_top),
                .i_ppc               (o_decode.ppc),
                .o_next              (next),
                .o_clear_from_decode (clear_from_decode_nxt),
                .o_clear_btb         (clear_btb_nxt),
                .o_push              (push),
                .o_pop               (pop),
                .o_pc_from_decode    (pc_from_decode_nxt),
                .o_push_addr         (push_addr)
        );

        predecode_stage u_predecode_stage (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_ctrl              (i_ctrl),
                .i_next              (next),
                .i_clear_from_decode (clear_from_decode_nxt),
                .i_clear_btb         (clear_btb_nxt),
                .i_pc_from_decode    (pc_from_decode_nxt),
                .o_decode            (o_decode),
                .o_clear_from_decode (o_clear_from_decode),
                .o_clear_btb         (o_clear_btb),
                .o_advance           (advance),
                .o_pc_from_decode    (o_pc_from_decode)
        );

endmodule

//--- hw/predecode_stage.sv
// Pre-decode output register that applies the clear and stall priority chain and flags advances.

`timescale 1ns/1ps

module predecode_stage
        import predecode_isa_pkg::*, predecode_pipe_pkg::*;
(
        input  logic           i_clk,
        input  logic           i_reset,
        input  pipe_ctrl_t     i_ctrl,
        input  decode_bundle_t i_next,
        input  logic           i_clear_from_decode,
        input  logic           i_clear_btb,
        input  addr_t          i_pc_from_decode,
        output decode_bundle_t o_decode,
        output logic           o_clear_from_decode,
        output logic           o_clear_btb,
        output logic           o_advance,
        output addr_t          o_pc_from_decode
);

        // No clear, no stall and no pending decode clear.
        assign o_advance = !i_ctrl.clear_wb && !i_ctrl.stall_data && !i_ctrl.clear_alu &&
                           !i_ctrl.stall_issue && !o_clear_from_decode;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_ctrl.clear_wb)
                begin
                        o_decode.valid      <= 1'b0;
                        o_decode.taken      <= SNT;
                        o_clear_from_decode <= 1'b0;
                        o_clear_btb         <= 1'b0;
                end
                else if (i_ctrl.stall_data)
                begin
                        // Hold.
                end
                else if (i_ctrl.clear_alu)
                begin
                        o_decode.valid      <= 1'b0;
                        o_decode.taken      <= SNT;
                        o_clear_from_decode <= 1'b0;
                        o_clear_btb         <= 1'b0;
                end
                else if (i_ctrl.stall_issue)
                begin
                        // Hold.
                end
                else if (o_clear_from_decode)
                begin
                        // Fetch is redirecting; drop this instruction.
                        o_decode.valid      <= 1'b0;
                        o_decode.taken      <= SNT;
                        o_clear_from_decode <= 1'b0;
                        o_clear_btb         <= 1'b0;
                end
                else
                begin
                        o_decode            <= i_next;
                        o_clear_from_decode <= i_clear_from_decode;
                        o_clear_btb         <= i_clear_btb;
                        o_pc_from_decode    <= i_pc_from_decode;
                end
        end

endmodule

//--- hw/branch_resolve.sv
// Combinational branch prediction check that builds the next decode bundle and stack requests.

`timescale 1ns/1ps

module branch_resolve
        import predecode_isa_pkg::*, predecode_pipe_pkg::*;
(
        input  fetch_bundle_t  i_fetch,
        input  branch_class_e  i_class,
        input  addr_t          i_offset,
        input  addr_t          i_ras_top,
        input  addr_t          i_ppc,
        output decode_bundle_t o_next,
        output logic           o_clear_from_decode,
        output logic           o_clear_btb,
        output logic           o_push,
        output logic           o_pop,
        output addr_t          o_pc_from_decode,
        output addr_t          o_push_addr
);

        cond_t cond;
        addr_t pc_plus_4;
        addr_t target;
        logic  pred_taken;

        assign cond       = i_fetch.instr[31:28];
        assign pc_plus_4  = i_fetch.pc + 32'd4;
        assign pred_taken = (i_fetch.taken == WT) || (i_fetch.taken == ST) || (cond == COND_AL);

        // Call target or popped return address.
        assign target = (i_class == CLS_CALL) ? i_fetch.pc_plus_8 + i_offset : i_ras_top;

        // BL saves the following instruction.
        assign o_push_addr = pc_plus_4;

        always_comb
        begin
                o_next.valid        = i_fetch.valid;
                o_next.instr        = i_fetch.instr;
                o_next.pc           = i_fetch.pc;
                o_next.taken        = i_fetch.taken;
                o_next.ppc          = i_ppc;
                o_clear_from_decode = 1'b0;
                o_clear_btb         = 1'b0;
                o_pc_from_decode    = '0;
                o_push              = 1'b0;
                o_pop               = 1'b0;

                if (!i_fetch.valid)
                begin
                        o_next.taken = SNT;
                end
                else
                begin
                        case (i_class)
                        CLS_CALL, CLS_RETURN:
                        begin
                                if (pred_taken)
                                begin
                                        o_pc_from_decode    = target;
                                        o_next.ppc          = target;
                                        // BTB missed or pointed elsewhere.
                                        o_clear_from_decode = !i_fetch.pred_valid ||
                                                              (i_fetch.pred_target != target);
                                        if (cond == COND_AL)
                                                o_next.taken = ST;
                                        o_push = (i_class == CLS_CALL) && i_fetch.instr[24];
                                        o_pop  = (i_class == CLS_RETURN);
                                end
                                else
                                begin
                                        o_next.ppc = pc_plus_4;
                                end
                        end

                        CLS_JUMP_TABLE:
                        begin
                                // Trust the BTB.
                        end

                        default:
                        begin
                                o_next.taken = SNT;
                                // Not a branch, so a BTB hit is stale.
                                if (i_fetch.pred_valid)
                                begin
                                        o_clear_from_decode = 1'b1;
                                        o_clear_btb         = 1'b1;
                                        o_pc_from_decode    = pc_plus_4;
                                        o_next.ppc          = pc_plus_4;
                                end
                        end
                        endcase
                end
        end

endmodule

//--- hw/return_addr_stack.sv
// Return address stack whose push and pop take effect only on a committing pipeline advance.

`timescale 1ns/1ps

module return_addr_stack
        import predecode_isa_pkg::*;
#(
        parameter int RAS_DEPTH = 8
)
(
        input  logic  i_clk,
        input  logic  i_reset,
        input  logic  i_commit,
        input  logic  i_push,
        input  logic  i_pop,
        input  addr_t i_push_addr,
        output addr_t o_top
);

        localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
        localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(RAS_DEPTH - 1);

        addr_t [RAS_DEPTH-1:0] ras_q;
        logic  [PTR_W-1:0]     ptr_q;
        logic  [PTR_W-1:0]     ptr_inc;
        logic  [PTR_W-1:0]     ptr_dec;

        // Pointer wraps in both directions.
        assign ptr_inc = (ptr_q == PTR_MAX) ? '0 : ptr_q + 1'b1;
        assign ptr_dec = (ptr_q == '0) ? PTR_MAX : ptr_q - 1'b1;

        // Most recent push sits just below the pointer.
        assign o_top = ras_q[ptr_dec];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        ras_q <= '0;
                        ptr_q <= '0;
                end
                else if (i_commit)
                begin
                        if (i_push)
                        begin
                                ras_q[ptr_q] <= i_push_addr;
                                ptr_q        <= ptr_inc;
                        end
                        else if (i_pop)
                        begin
                                ptr_q <= ptr_dec;
                        end
                end
        end

endmodule

//--- hw/branch_classify.sv
// Combinational classifier that sorts one instruction into call, return, jump table or other.

`timescale 1ns/1ps

module branch_classify
        import predecode_isa_pkg::*;
(
        input  instr_t        i_instr,
        output branch_class_e o_class,
        output addr_t         o_offset
);

        reg_t    rd;
        reg_t    rn;
        reg_t    rm;
        opcode_t opcode;
        logic    is_call;
        logic    is_bx_lr;
        logic    is_mov_pc_lr;
        logic    is_ldm_pc;
        logic    is_ldr;
        logic    is_dp_pc;

        assign rd     = i_instr[15:12];
        assign rn     = i_instr[19:16];
        assign rm     = i_instr[3:0];
        assign opcode = i_instr[24:21];

        // B or BL.
        assign is_call = (i_instr[27:25] == 3'b101);

        // ------------------------------
        // Return patterns.
        // ------------------------------

        assign is_bx_lr = (i_instr[27:4] == 24'h12FFF1) && (rm == REG_LR);

        // Register form, no S bit, no shift.
        assign is_mov_pc_lr = (i_instr[27:25] == 3'b000) && (opcode == OP_MOV) &&
                              !i_instr[20] && (rn == 4'd0) && (rd == REG_PC) &&
                              (i_instr[11:4] == 8'd0) && (rm == REG_LR);

        assign is_ldm_pc = (i_instr[27:25] == 3'b100) && i_instr[20] && i_instr[15];

        // Single load, immediate or register offset.
        assign is_ldr = (i_instr[27:26] == 2'b01) && (!i_instr[25] || !i_instr[4]) &&
                        i_instr[20] && (rd == REG_PC);

        // ADD or MOV into PC, excluding the multiply and extra load/store space.
        assign is_dp_pc = (i_instr[27:26] == 2'b00) && (rd == REG_PC) &&
                          (i_instr[25] || !i_instr[4] || !i_instr[7]) &&
                          ((opcode == OP_ADD) || (opcode == OP_MOV));

        always_comb
        begin
                if (is_call)
                        o_class = CLS_CALL;
                else if (is_bx_lr || is_mov_pc_lr || is_ldm_pc || (is_ldr && rn == REG_SP))
                        o_class = CLS_RETURN;
                else if (is_ldr || is_dp_pc)
                        o_class = CLS_JUMP_TABLE;
                else
                        o_class = CLS_OTHER;
        end

        // Word offset, sign extended.
        assign o_offset = {{6{i_instr[23]}}, i_instr[23:0], 2'b00};

endmodule

//--- hw/predecode_pipe_pkg.sv
// Packed bundles carried between fetch, the pre-decode stage and the pipeline control.

package predecode_pipe_pkg;

        import predecode_isa_pkg::*;

        // Instruction as delivered by fetch, with its BTB prediction.
        typedef struct packed {
                logic   valid;
                instr_t instr;
                addr_t  pc;
                addr_t  pc_plus_8;
                taken_e taken;
                logic   pred_valid;
                addr_t  pred_target;
        } fetch_bundle_t;

        // Instruction leaving the stage towards decode.
        typedef struct packed {
                logic   valid;
                instr_t instr;
                addr_t  pc;
                taken_e taken;
                // Predicted next PC.
                addr_t  ppc;
        } decode_bundle_t;

        // Clear and stall inputs, highest priority first.
        typedef struct packed {
                logic clear_wb;
                logic stall_data;
                logic clear_alu;
                logic stall_issue;
        } pipe_ctrl_t;

endpackage

//--- hw/predecode_isa_pkg.sv
// ARM instruction field types, opcode constants and predictor enums used by the pre-decode stage.

package predecode_isa_pkg;

        // ------------------------------
        // Field types.
        // ------------------------------

        // Full instruction word.
        typedef logic [31:0] instr_t;

        // Byte address.
        typedef logic [31:0] addr_t;

        // Condition field, bits 31:28.
        typedef logic [3:0] cond_t;

        // Register number.
        typedef logic [3:0] reg_t;

        // Data-processing opcode, bits 24:21.
        typedef logic [3:0] opcode_t;

        // ------------------------------
        // Constants.
        // ------------------------------

        // Always execute.
        localparam cond_t COND_AL = 4'hE;

        localparam reg_t REG_PC = 4'd15;
        localparam reg_t REG_LR = 4'd14;
        localparam reg_t REG_SP = 4'd13;

        localparam opcode_t OP_ADD = 4'b0100;
        localparam opcode_t OP_MOV = 4'b1101;

        // ------------------------------
        // Enums.
        // ------------------------------

        // Two-bit saturating branch predictor state.
        typedef enum logic [1:0] {
                SNT = 2'd0,
                WNT = 2'd1,
                WT  = 2'd2,
                ST  = 2'd3
        } taken_e;

        // Branch class as seen by the pre-decoder.
        typedef enum logic [1:0] {
                CLS_CALL       = 2'd0,
                CLS_RETURN     = 2'd1,
                CLS_JUMP_TABLE = 2'd2,
                CLS_OTHER      = 2'd3
        } branch_class_e;

endpackage
